/* logic/axil_pkg.sv */
/*
 * AXI4-Lite channel types for a 6-bit byte address and 32-bit data.
 * no prot, no burst; the slave only ever answers OKAY
 */
package axil_pkg;

    // ==========================================================
    // widths and response codes
    // ==========================================================
    localparam int AXIL_ADDR_W = 6;
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

    // ==========================================================
    // channel bundles
    // ==========================================================
    // master to slave
    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   awvalid;
        logic [AXIL_DATA_W-1:0] wdata;
        logic [AXIL_STRB_W-1:0] wstrb;
        logic                   wvalid;
        logic                   bready;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   arvalid;
        logic                   rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic [1:0]             bresp;
        logic                   bvalid;
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
        logic                   rvalid;
    } axil_rsp_t;

endpackage

/* logic/dma_regs_pkg.sv */
/*
 * register map of the DMA control slave. unmapped addresses decode
 * to an all-zero select, so they read zero and drop writes
 */
package dma_regs_pkg;

    localparam int REG_ADDR_W = 6;
    localparam int REG_DATA_W = 32;
    localparam int DMA_PTR_W  = 32;
    // bit 0 done, bit 1 ready
    localparam int IRQ_SRC_N  = 2;

    // ==========================================================
    // address map
    // ==========================================================
    localparam logic [REG_ADDR_W-1:0] ADDR_AP_CTRL         = 6'h00;
    localparam logic [REG_ADDR_W-1:0] ADDR_GIE             = 6'h04;
    localparam logic [REG_ADDR_W-1:0] ADDR_IER             = 6'h08;
    localparam logic [REG_ADDR_W-1:0] ADDR_ISR             = 6'h0c;
    localparam logic [REG_ADDR_W-1:0] ADDR_RDMA_PARAM_PTR  = 6'h14;
    localparam logic [REG_ADDR_W-1:0] ADDR_RDMA_INFMAP_PTR = 6'h18;
    localparam logic [REG_ADDR_W-1:0] ADDR_WDMA_MEM_PTR    = 6'h1c;

    // one-hot, one bit per mapped register
    typedef struct packed {
        logic ap_ctrl;
        logic gie;
        logic ier;
        logic isr;
        logic param_ptr;
        logic infmap_ptr;
        logic wdma_ptr;
    } reg_sel_t;

    typedef struct packed {
        logic                    valid;
        reg_sel_t                sel;
        logic [REG_DATA_W-1:0]   data;
        logic [REG_DATA_W/8-1:0] strb;
    } reg_wr_t;

    // accept is the AR handshake pulse
    typedef struct packed {
        logic     accept;
        reg_sel_t sel;
    } reg_rd_t;

    // field view of ap_ctrl, msb first
    typedef struct packed {
        logic [21:0] rsvd_hi;
        logic        interrupt;
        logic [2:0]  rsvd_mid;
        logic        wdma_done;
        logic        start_infmap;
        logic        ready;
        logic        idle;
        logic        done;
        logic        start_param;
    } ap_ctrl_bits_t;

    typedef union packed {
        logic [REG_DATA_W-1:0] word;
        ap_ctrl_bits_t         bits;
    } ap_ctrl_word_u;

    typedef struct packed {
        logic [DMA_PTR_W-1:0] param;
        logic [DMA_PTR_W-1:0] infmap;
        logic [DMA_PTR_W-1:0] wdma;
    } dma_ptrs_t;

    // shared by both channels
    function automatic reg_sel_t reg_decode(input logic [REG_ADDR_W-1:0] addr);
        reg_sel_t sel;
        sel            = '0;
        sel.ap_ctrl    = (addr == ADDR_AP_CTRL);
        sel.gie        = (addr == ADDR_GIE);
        sel.ier        = (addr == ADDR_IER);
        sel.isr        = (addr == ADDR_ISR);
        sel.param_ptr  = (addr == ADDR_RDMA_PARAM_PTR);
        sel.infmap_ptr = (addr == ADDR_RDMA_INFMAP_PTR);
        sel.wdma_ptr   = (addr == ADDR_WDMA_MEM_PTR);
        return sel;
    endfunction

endpackage

/* logic/axil_wr_channel.sv */
/*
 * AXI4-Lite write side. AW must come before W, one write in flight,
 * response is always OKAY
 */
`timescale 1ns/1ps

module axil_wr_channel (
    input  logic                   ACLK,
    input  logic                   ARESET,
    input  axil_pkg::axil_req_t    i_req,
    output logic                   o_awready,
    output logic                   o_wready,
    output logic                   o_bvalid,
    output logic [1:0]             o_bresp,
    output dma_regs_pkg::reg_wr_t  o_wr
);
    import axil_pkg::*;
    import dma_regs_pkg::*;

    typedef enum logic [1:0] {WR_RESET, WR_IDLE, WR_DATA, WR_RESP} wr_state_t;

    wr_state_t              state;
    wr_state_t              state_nx;
    logic [AXIL_ADDR_W-1:0] wr_addr;
    logic                   aw_hs;
    logic                   w_hs;

    assign aw_hs = i_req.awvalid && o_awready;
    assign w_hs  = i_req.wvalid && o_wready;

    // ==========================================================
    // write FSM
    // ==========================================================
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            state <= WR_RESET;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            WR_RESET: state_nx = WR_IDLE;
            WR_IDLE:  if (i_req.awvalid) state_nx = WR_DATA;
            WR_DATA:  if (i_req.wvalid) state_nx = WR_RESP;
            WR_RESP:  if (i_req.bready) state_nx = WR_IDLE;
            default:  state_nx = WR_RESET;
        endcase
    end

    // address held until the W beat arrives
    always_ff @(posedge ACLK) begin
        if (aw_hs) begin
            wr_addr <= i_req.awaddr;
        end
    end

    assign o_awready = (state == WR_IDLE);
    assign o_wready  = (state == WR_DATA);
    assign o_bvalid  = (state == WR_RESP);
    assign o_bresp   = AXIL_RESP_OKAY;

    // request lives only in the W handshake cycle
    assign o_wr.valid = w_hs;
    assign o_wr.sel   = reg_decode(wr_addr);
    assign o_wr.data  = i_req.wdata;
    assign o_wr.strb  = i_req.wstrb;

    // response must not drop before the master takes it
    a_bvalid_hold: assert property (@(posedge ACLK) disable iff (ARESET)
        o_bvalid && !i_req.bready |=> o_bvalid)
        else $error("bvalid dropped without bready");

endmodule

/* logic/axil_rd_channel.sv */
/*
 * AXI4-Lite read side, one cycle of latency. rdata is sampled on the
 * AR handshake and held until rready
 */
`timescale 1ns/1ps

module axil_rd_channel (
    input  logic                              ACLK,
    input  logic                              ARESET,
    input  axil_pkg::axil_req_t               i_req,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]  i_ctrl_word,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]  i_irq_word,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]  i_ptr_word,
    output logic                              o_arready,
    output logic                              o_rvalid,
    output logic [axil_pkg::AXIL_DATA_W-1:0]  o_rdata,
    output logic [1:0]                        o_rresp,
    output dma_regs_pkg::reg_rd_t             o_rd
);
    import axil_pkg::*;
    import dma_regs_pkg::*;

    typedef enum logic [1:0] {RD_RESET, RD_IDLE, RD_DATA} rd_state_t;

    rd_state_t              state;
    rd_state_t              state_nx;
    logic [AXIL_DATA_W-1:0] rdata;
    logic                   ar_hs;
    logic                   r_hs;

    assign ar_hs = i_req.arvalid && o_arready;
    assign r_hs  = o_rvalid && i_req.rready;

    // ==========================================================
    // read FSM
    // ==========================================================
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            state <= RD_RESET;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            RD_RESET: state_nx = RD_IDLE;
            RD_IDLE:  if (i_req.arvalid) state_nx = RD_DATA;
            RD_DATA:  if (r_hs) state_nx = RD_IDLE;
            default:  state_nx = RD_RESET;
        endcase
    end

    // blocks answer zero when unselected, so OR is the mux
    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            rdata <= i_ctrl_word | i_irq_word | i_ptr_word;
        end
    end

    // select follows the live araddr
    assign o_rd.accept = ar_hs;
    assign o_rd.sel    = reg_decode(i_req.araddr);

    assign o_arready = (state == RD_IDLE);
    assign o_rvalid  = (state == RD_DATA);
    assign o_rdata   = rdata;
    assign o_rresp   = AXIL_RESP_OKAY;

    a_rdata_hold: assert property (@(posedge ACLK) disable iff (ARESET)
        o_rvalid && !i_req.rready |=> o_rvalid && $stable(o_rdata))
        else $error("read data changed under back-pressure");

endmodule

/* logic/ap_ctrl_regs.sv */
/*
 * ap_ctrl at 0x00. start bits clear on ap_ready, done/ready/wdma_done
 * clear on read; a set in the same cycle wins over the clear
 */
`timescale 1ns/1ps

module ap_ctrl_regs (
    input  logic                                  ACLK,
    input  logic                                  ARESET,
    input  dma_regs_pkg::reg_wr_t                 i_wr,
    input  dma_regs_pkg::reg_rd_t                 i_rd,
    input  logic                                  i_ap_done,
    input  logic                                  i_ap_ready,
    input  logic                                  i_ap_idle,
    input  logic                                  i_ap_wdma_done,
    input  logic                                  i_interrupt,
    output logic                                  o_ap_start_param,
    output logic                                  o_ap_start_infmap,
    output logic [dma_regs_pkg::IRQ_SRC_N-1:0]    o_irq_src,
    output logic [dma_regs_pkg::REG_DATA_W-1:0]   o_rd_word
);
    import dma_regs_pkg::*;

    ap_ctrl_word_u wr_u;
    ap_ctrl_word_u rd_u;
    logic          wr_hit;
    logic          rd_clr;
    logic          done;
    logic          ready;
    logic          wdma_done;
    logic          idle;
    logic          done_evt;
    logic          ready_evt;

    assign wr_u.word = i_wr.data;
    // only byte 0 carries writable bits
    assign wr_hit    = i_wr.valid && i_wr.sel.ap_ctrl && i_wr.strb[0];
    assign rd_clr    = i_rd.accept && i_rd.sel.ap_ctrl;

    // ==========================================================
    // start bits, cleared by the accelerator handshake
    // ==========================================================
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            o_ap_start_param  <= 1'b0;
            o_ap_start_infmap <= 1'b0;
        end else begin
            if (wr_hit && wr_u.bits.start_param)
                o_ap_start_param <= 1'b1;
            else if (i_ap_ready)
                o_ap_start_param <= 1'b0;
            if (wr_hit && wr_u.bits.start_infmap)
                o_ap_start_infmap <= 1'b1;
            else if (i_ap_ready)
                o_ap_start_infmap <= 1'b0;
        end
    end

    // ==========================================================
    // sticky status and idle
    // ==========================================================
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            done      <= 1'b0;
            ready     <= 1'b0;
            wdma_done <= 1'b0;
            idle      <= 1'b0;
            done_evt  <= 1'b0;
            ready_evt <= 1'b0;
        end else begin
            done      <= i_ap_done || (done && !rd_clr);
            ready     <= i_ap_ready || (ready && !rd_clr);
            wdma_done <= i_ap_wdma_done || (wdma_done && !rd_clr);
            idle      <= i_ap_idle;
            // events for the ISR
            done_evt  <= i_ap_done;
            ready_evt <= i_ap_ready;
        end
    end

    assign o_irq_src = {ready_evt, done_evt};

    always_comb begin
        rd_u.word              = '0;
        rd_u.bits.start_param  = o_ap_start_param;
        rd_u.bits.done         = done;
        rd_u.bits.idle         = idle;
        rd_u.bits.ready        = ready;
        rd_u.bits.start_infmap = o_ap_start_infmap;
        rd_u.bits.wdma_done    = wdma_done;
        rd_u.bits.interrupt    = i_interrupt;
    end

    assign o_rd_word = i_rd.sel.ap_ctrl ? rd_u.word : '0;

    a_no_start_in_reset: assert property (@(posedge ACLK)
        ARESET |=> !(o_ap_start_param || o_ap_start_infmap))
        else $error("start bit set while in reset");

endmodule

/* logic/irq_regs.sv */
/*
 * GIE, IER and ISR. ISR clears on read; o_interrupt is registered
 * and lags the ISR by one edge
 */
`timescale 1ns/1ps

module irq_regs (
    input  logic                                  ACLK,
    input  logic                                  ARESET,
    input  dma_regs_pkg::reg_wr_t                 i_wr,
    input  dma_regs_pkg::reg_rd_t                 i_rd,
    input  logic [dma_regs_pkg::IRQ_SRC_N-1:0]    i_irq_src,
    output logic                                  o_interrupt,
    output logic [dma_regs_pkg::REG_DATA_W-1:0]   o_rd_word
);
    import dma_regs_pkg::*;

    logic                 gie;
    logic [IRQ_SRC_N-1:0] ier;
    logic [IRQ_SRC_N-1:0] isr;
    logic                 wr_b0;

    assign wr_b0 = i_wr.valid && i_wr.strb[0];

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            gie         <= 1'b0;
            ier         <= '0;
            isr         <= '0;
            o_interrupt <= 1'b0;
        end else begin
            if (wr_b0 && i_wr.sel.gie)
                gie <= i_wr.data[0];
            if (wr_b0 && i_wr.sel.ier)
                ier <= i_wr.data[IRQ_SRC_N-1:0];
            // enabled source sets, ISR read clears
            for (int i = 0; i < IRQ_SRC_N; i++) begin
                if (ier[i] && i_irq_src[i])
                    isr[i] <= 1'b1;
                else if (i_rd.accept && i_rd.sel.isr)
                    isr[i] <= 1'b0;
            end
            o_interrupt <= gie && (|isr);
        end
    end

    // selects are one-hot, at most one term is live
    assign o_rd_word = ({REG_DATA_W{i_rd.sel.gie}} & REG_DATA_W'(gie))
                     | ({REG_DATA_W{i_rd.sel.ier}} & REG_DATA_W'(ier))
                     | ({REG_DATA_W{i_rd.sel.isr}} & REG_DATA_W'(isr));

    a_gie_gates_irq: assert property (@(posedge ACLK) disable iff (ARESET)
        !gie |=> !o_interrupt)
        else $error("interrupt raised with GIE low");

endmodule

/* logic/dma_ptr_regs.sv */
/*
 * the three DMA base pointers. each byte lane is written only when its
 * strobe is set
 */
`timescale 1ns/1ps

module dma_ptr_regs (
    input  logic                                  ACLK,
    input  logic                                  ARESET,
    input  dma_regs_pkg::reg_wr_t                 i_wr,
    input  dma_regs_pkg::reg_rd_t                 i_rd,
    output dma_regs_pkg::dma_ptrs_t               o_ptrs,
    output logic [dma_regs_pkg::REG_DATA_W-1:0]   o_rd_word
);
    import dma_regs_pkg::*;

    logic [DMA_PTR_W-1:0] mask;

    // strobe bit per byte lane
    always_comb begin
        for (int b = 0; b < DMA_PTR_W / 8; b++) begin
            mask[b*8 +: 8] = {8{i_wr.strb[b]}};
        end
    end

    function automatic logic [DMA_PTR_W-1:0] merge(input logic [DMA_PTR_W-1:0] old);
        return (i_wr.data & mask) | (old & ~mask);
    endfunction

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            o_ptrs <= '0;
        end else if (i_wr.valid) begin
            if (i_wr.sel.param_ptr)
                o_ptrs.param <= merge(o_ptrs.param);
            if (i_wr.sel.infmap_ptr)
                o_ptrs.infmap <= merge(o_ptrs.infmap);
            if (i_wr.sel.wdma_ptr)
                o_ptrs.wdma <= merge(o_ptrs.wdma);
        end
    end

    assign o_rd_word = ({DMA_PTR_W{i_rd.sel.param_ptr}}  & o_ptrs.param)
                     | ({DMA_PTR_W{i_rd.sel.infmap_ptr}} & o_ptrs.infmap)
                     | ({DMA_PTR_W{i_rd.sel.wdma_ptr}}   & o_ptrs.wdma);

endmodule

/* logic/dma_ctrl_s_axi.sv */
/*
 * AXI4-Lite control slave for the DMA accelerator. no clock enable,
 * no auto-restart; unmapped addresses read zero
 */
`timescale 1ns/1ps

module dma_ctrl_s_axi (
    input  logic                      ACLK,
    input  logic                      ARESET,
    input  axil_pkg::axil_req_t       i_axil,
    output axil_pkg::axil_rsp_t       o_axil,
    input  logic                      i_ap_done,
    input  logic                      i_ap_ready,
    input  logic                      i_ap_idle,
    input  logic                      i_ap_wdma_done,
    output logic                      o_ap_start_param,
    output logic                      o_ap_start_infmap,
    output dma_regs_pkg::dma_ptrs_t   o_ptrs,
    output logic                      o_interrupt
);
    import axil_pkg::*;
    import dma_regs_pkg::*;

    reg_wr_t                wr;
    reg_rd_t                rd;
    logic [AXIL_DATA_W-1:0] ctrl_word;
    logic [AXIL_DATA_W-1:0] irq_word;
    logic [AXIL_DATA_W-1:0] ptr_word;
    logic [IRQ_SRC_N-1:0]   irq_src;

    // ==========================================================
    // bus channels
    // ==========================================================
    axil_wr_channel u_wr (
        .ACLK      (ACLK),
        .ARESET    (ARESET),
        .i_req     (i_axil),
        .o_awready (o_axil.awready),
        .o_wready  (o_axil.wready),
        .o_bvalid  (o_axil.bvalid),
        .o_bresp   (o_axil.bresp),
        .o_wr      (wr)
    );

    axil_rd_channel u_rd (
        .ACLK        (ACLK),
        .ARESET      (ARESET),
        .i_req       (i_axil),
        .i_ctrl_word (ctrl_word),
        .i_irq_word  (irq_word),
        .i_ptr_word  (ptr_word),
        .o_arready   (o_axil.arready),
        .o_rvalid    (o_axil.rvalid),
        .o_rdata     (o_axil.rdata),
        .o_rresp     (o_axil.rresp),
        .o_rd        (rd)
    );

    // ==========================================================
    // register blocks
    // ==========================================================
    ap_ctrl_regs u_ctrl (
        .ACLK              (ACLK),
        .ARESET            (ARESET),
        .i_wr              (wr),
        .i_rd              (rd),
        .i_ap_done         (i_ap_done),
        .i_ap_ready        (i_ap_ready),
        .i_ap_idle         (i_ap_idle),
        .i_ap_wdma_done    (i_ap_wdma_done),
        .i_interrupt       (o_interrupt),
        .o_ap_start_param  (o_ap_start_param),
        .o_ap_start_infmap (o_ap_start_infmap),
        .o_irq_src         (irq_src),
        .o_rd_word         (ctrl_word)
    );

    // interrupt level loops back into ap_ctrl bit 9
    irq_regs u_irq (
        .ACLK        (ACLK),
        .ARESET      (ARESET),
        .i_wr        (wr),
        .i_rd        (rd),
        .i_irq_src   (irq_src),
        .o_interrupt (o_interrupt),
        .o_rd_word   (irq_word)
    );

    dma_ptr_regs u_ptr (
        .ACLK      (ACLK),
        .ARESET    (ARESET),
        .i_wr      (wr),
        .i_rd      (rd),
        .o_ptrs    (o_ptrs),
        .o_rd_word (ptr_word)
    );

endmodule

/* include/tb_axil_tasks.svh */
/*
 * AXI4-Lite master tasks, included inside the testbench module.
 * call them 1 ns after a rising edge; they return at the same phase
 */
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// one write; bready held low for bstall cycles once bvalid is up
task automatic axil_write(input logic [5:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input int bstall);
    int n;
    cur_waddr        = addr;
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    n = 0;
    while (!axil_rsp.awready) begin
        if (n == WAIT_LIMIT)
            abort_run("timeout waiting for awready");
        n++;
        next_cycle();
    end
    // AW handshake on this edge
    next_cycle();
    axil_req.awvalid = 1'b0;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    axil_req.wvalid  = 1'b1;
    n = 0;
    while (!axil_rsp.wready) begin
        if (n == WAIT_LIMIT)
            abort_run("timeout waiting for wready");
        n++;
        next_cycle();
    end
    next_cycle();
    axil_req.wvalid = 1'b0;
    n = 0;
    while (!axil_rsp.bvalid) begin
        if (n == WAIT_LIMIT)
            abort_run("timeout waiting for bvalid");
        n++;
        next_cycle();
    end
    // back-pressure on the response
    repeat (bstall) next_cycle();
    axil_req.bready = 1'b1;
    next_cycle();
    axil_req.bready = 1'b0;
endtask

// one read; rready held low for rstall cycles, data taken before the handshake
task automatic axil_read(input logic [5:0] addr, input int rstall,
                         output logic [31:0] data);
    int n;
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    n = 0;
    while (!axil_rsp.arready) begin
        if (n == WAIT_LIMIT)
            abort_run("timeout waiting for arready");
        n++;
        next_cycle();
    end
    next_cycle();
    axil_req.arvalid = 1'b0;
    n = 0;
    while (!axil_rsp.rvalid) begin
        if (n == WAIT_LIMIT)
            abort_run("timeout waiting for rvalid");
        n++;
        next_cycle();
    end
    repeat (rstall) next_cycle();
    data            = axil_rsp.rdata;
    axil_req.rready = 1'b1;
    next_cycle();
    axil_req.rready = 1'b0;
endtask

`endif

/* test/tb_dma_ctrl_s_axi.sv */
/*
 * testbench for the DMA control slave. checks are assertions and the
 * run stops at the first one that fails; inputs move 1 ns after each edge
 */
`timescale 1ns/1ps

module tb_dma_ctrl_s_axi;
    import axil_pkg::*;
    import dma_regs_pkg::*;

    localparam int WAIT_LIMIT = 40;

    logic      ACLK;
    logic      ARESET;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    logic      ap_done;
    logic      ap_ready;
    logic      ap_idle;
    logic      ap_wdma_done;
    logic      start_param;
    logic      start_infmap;
    dma_ptrs_t ptrs;
    logic      irq;

    integer      seed;
    logic [5:0]  cur_waddr;
    logic        irq_must_be_low;

    dma_ctrl_s_axi dut (
        .ACLK              (ACLK),
        .ARESET            (ARESET),
        .i_axil            (axil_req),
        .o_axil            (axil_rsp),
        .i_ap_done         (ap_done),
        .i_ap_ready        (ap_ready),
        .i_ap_idle         (ap_idle),
        .i_ap_wdma_done    (ap_wdma_done),
        .o_ap_start_param  (start_param),
        .o_ap_start_infmap (start_infmap),
        .o_ptrs            (ptrs),
        .o_interrupt       (irq)
    );

    always #4 ACLK = ~ACLK;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on a failed check");
    endtask

    task automatic next_cycle();
        @(posedge ACLK);
        #1;
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp)
            else abort_run($sformatf("FAIL at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while (irq !== level) begin
            if (n == WAIT_LIMIT)
                abort_run("timeout waiting for the interrupt output to change");
            n++;
            next_cycle();
        end
    endtask

    // reference byte merge with one lane per strobe bit
    function automatic logic [31:0] strobe_merge(input logic [31:0] old,
                                                 input logic [31:0] data,
                                                 input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++)
            if (strb[b])
                res[b*8 +: 8] = data[b*8 +: 8];
        return res;
    endfunction

    function automatic logic [31:0] ptr_out(input int p);
        case (p)
            0:       return ptrs.param;
            1:       return ptrs.infmap;
            default: return ptrs.wdma;
        endcase
    endfunction

    `include "tb_axil_tasks.svh"

    // ==========================================================
    // channel protocol
    // ==========================================================
    a_bresp_okay: assert property (@(posedge ACLK) disable iff (ARESET)
        axil_rsp.bvalid |-> axil_rsp.bresp == AXIL_RESP_OKAY)
        else abort_run($sformatf("FAIL at %0t: bresp is not OKAY", $time));
    a_rresp_okay: assert property (@(posedge ACLK) disable iff (ARESET)
        axil_rsp.rvalid |-> axil_rsp.rresp == AXIL_RESP_OKAY)
        else abort_run($sformatf("FAIL at %0t: rresp is not OKAY", $time));
    a_bvalid_held: assert property (@(posedge ACLK) disable iff (ARESET)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else abort_run($sformatf("FAIL at %0t: bvalid fell before bready", $time));
    a_rvalid_held: assert property (@(posedge ACLK) disable iff (ARESET)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else abort_run($sformatf("FAIL at %0t: rvalid or rdata moved before rready", $time));
    // covers the reset cycles and the first cycle after
    a_reset_quiet: assert property (@(posedge ACLK)
        ARESET |=> !axil_rsp.awready && !axil_rsp.arready && !axil_rsp.bvalid
                   && !axil_rsp.rvalid)
        else abort_run($sformatf("FAIL at %0t: channel active around reset", $time));

    // ==========================================================
    // control and interrupt timing
    // ==========================================================
    a_start_param_set: assert property (@(posedge ACLK) disable iff (ARESET)
        axil_req.wvalid && axil_rsp.wready && cur_waddr == ADDR_AP_CTRL
        && axil_req.wstrb[0] && axil_req.wdata[0] |=> start_param)
        else abort_run($sformatf("FAIL at %0t: start_param did not rise", $time));
    a_start_infmap_set: assert property (@(posedge ACLK) disable iff (ARESET)
        axil_req.wvalid && axil_rsp.wready && cur_waddr == ADDR_AP_CTRL
        && axil_req.wstrb[0] && axil_req.wdata[4] |=> start_infmap)
        else abort_run($sformatf("FAIL at %0t: start_infmap did not rise", $time));
    a_start_clear: assert property (@(posedge ACLK) disable iff (ARESET)
        ap_ready && !(axil_req.wvalid && axil_rsp.wready) |=> !start_param && !start_infmap)
        else abort_run($sformatf("FAIL at %0t: start bits not cleared by ap_ready", $time));
    a_irq_bit9: assert property (@(posedge ACLK) disable iff (ARESET)
        axil_req.arvalid && axil_rsp.arready && axil_req.araddr == ADDR_AP_CTRL
        |=> axil_rsp.rdata[9] == $past(irq))
        else abort_run($sformatf("FAIL at %0t: ap_ctrl bit 9 differs from interrupt", $time));
    a_irq_gated: assert property (@(posedge ACLK) disable iff (ARESET)
        irq_must_be_low |-> !irq)
        else abort_run($sformatf("FAIL at %0t: interrupt high with GIE off", $time));

    // ==========================================================
    // stimulus
    // ==========================================================
    initial begin
        logic [31:0] rd_data;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic [31:0] exp_ptr [3];
        logic [5:0]  ptr_addr [3];
        seed            = 32'h1f47;
        ACLK            = 1'b0;
        ARESET          = 1'b1;
        axil_req        = '0;
        ap_done         = 1'b0;
        ap_ready        = 1'b0;
        ap_idle         = 1'b0;
        ap_wdma_done    = 1'b0;
        cur_waddr       = '0;
        irq_must_be_low = 1'b0;
        ptr_addr = '{ADDR_RDMA_PARAM_PTR, ADDR_RDMA_INFMAP_PTR, ADDR_WDMA_MEM_PTR};
        repeat (2) @(posedge ACLK);
        #1;
        ARESET = 1'b0;
        next_cycle();

        // pointers read zero after reset and then take two rounds of strobed writes
        for (int p = 0; p < 3; p++) begin
            exp_ptr[p] = '0;
            axil_read(ptr_addr[p], 0, rd_data);
            check_eq(rd_data, 32'h0, "pointer after reset");
        end
        for (int r = 0; r < 2; r++) begin
            for (int p = 0; p < 3; p++) begin
                wdata = 32'($random(seed));
                wstrb = 4'($random(seed));
                exp_ptr[p] = strobe_merge(exp_ptr[p], wdata, wstrb);
                axil_write(ptr_addr[p], wdata, wstrb, p + 2);
                check_eq(ptr_out(p), exp_ptr[p], "o_ptrs after write");
                axil_read(ptr_addr[p], 3, rd_data);
                check_eq(rd_data, exp_ptr[p], "pointer read-back");
            end
        end
        // unmapped holes
        axil_write(6'h10, 32'hffff_ffff, 4'hf, 0);
        axil_write(6'h3c, 32'hffff_ffff, 4'hf, 1);
        axil_read(6'h10, 0, rd_data);
        check_eq(rd_data, 32'h0, "unmapped 0x10 read");
        axil_read(6'h3c, 2, rd_data);
        check_eq(rd_data, 32'h0, "unmapped 0x3c read");
        for (int p = 0; p < 3; p++)
            check_eq(ptr_out(p), exp_ptr[p], "pointer after unmapped write");
        check_eq({start_infmap, start_param}, 32'h0, "start outputs after unmapped write");
        axil_read(ADDR_GIE, 0, rd_data);
        check_eq(rd_data, 32'h0, "GIE after unmapped write");
        axil_read(ADDR_IER, 0, rd_data);
        check_eq(rd_data, 32'h0, "IER after unmapped write");

        // start bits then the accelerator handshake
        axil_write(ADDR_AP_CTRL, 32'h11, 4'h1, 0);
        check_eq({start_infmap, start_param}, 32'h3, "start outputs");
        axil_read(ADDR_AP_CTRL, 0, rd_data);
        check_eq(rd_data & 32'h11, 32'h11, "start bits read-back");
        ap_ready = 1'b1;
        next_cycle();
        ap_ready = 1'b0;
        check_eq({start_infmap, start_param}, 32'h0, "start outputs after ap_ready");
        // drop the sticky ready left by the handshake
        axil_read(ADDR_AP_CTRL, 0, rd_data);

        // sticky status with idle high
        ap_done      = 1'b1;
        ap_wdma_done = 1'b1;
        ap_ready     = 1'b1;
        ap_idle      = 1'b1;
        next_cycle();
        ap_done      = 1'b0;
        ap_wdma_done = 1'b0;
        ap_ready     = 1'b0;
        axil_read(ADDR_AP_CTRL, 1, rd_data);
        check_eq(rd_data, 32'h2e, "ap_ctrl first read");
        axil_read(ADDR_AP_CTRL, 0, rd_data);
        check_eq(rd_data, 32'h04, "ap_ctrl second read");
        ap_idle = 1'b0;
        next_cycle();
        axil_read(ADDR_AP_CTRL, 0, rd_data);
        check_eq(rd_data, 32'h0, "ap_ctrl with idle low")

;

        // ISR still latches with GIE off while the output stays low
        irq_must_be_low = 1'b1;
        axil_write(ADDR_IER, 32'h3, 4'h1, 0);
        ap_done = 1'b1;
        next_cycle();
        ap_done = 1'b0;
        // ISR lands two edges after the pulse
        repeat (2) next_cycle();
        axil_read(ADDR_ISR, 0, rd_data);
        check_eq(rd_data, 32'h1, "ISR with GIE off");
        axil_read(ADDR_ISR, 0, rd_data);
        check_eq(rd_data, 32'h0, "ISR after clear");
        irq_must_be_low = 1'b0;

        // interrupt with GIE on
        axil_write(ADDR_GIE, 32'h1, 4'h1, 0);
        ap_done = 1'b1;
        next_cycle();
        ap_done  = 1'b0;
        ap_ready = 1'b1;
        next_cycle();
        ap_ready = 1'b0;
        wait_irq(1'b1);
        axil_read(ADDR_AP_CTRL, 0, rd_data);
        check_eq(rd_data & 32'h200, 32'h200, "ap_ctrl interrupt bit");
        axil_read(ADDR_ISR, 2, rd_data);
        check_eq(rd_data, 32'h3, "ISR with both sources");
        wait_irq(1'b0);
        axil_read(ADDR_ISR, 0, rd_data);
        check_eq(rd_data, 32'h0, "ISR after read");

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* dma_ctrl_s_axi.f */
+incdir+include
logic/axil_pkg.sv
logic/dma_regs_pkg.sv
logic/axil_wr_channel.sv
logic/axil_rd_channel.sv
logic/ap_ctrl_regs.sv
logic/irq_regs.sv
logic/dma_ptr_regs.sv
logic/dma_ctrl_s_axi.sv
test/tb_dma_ctrl_s_axi.sv

/* Bender.yml */
package:
  name: dma_ctrl_s_axi

sources:
  - logic/axil_pkg.sv
  - logic/dma_regs_pkg.sv
  - logic/axil_wr_channel.sv
  - logic/axil_rd_channel.sv
  - logic/ap_ctrl_regs.sv
  - logic/irq_regs.sv
  - logic/dma_ptr_regs.sv
  - logic/dma_ctrl_s_axi.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_dma_ctrl_s_axi.sv
